// File: rvc_expander.f
hdl/rvc_pkg.sv
hdl/rvc_quadrant0.sv
hdl/rvc_quadrant1.sv
hdl/rvc_quadrant2.sv
hdl/rvc_expander.sv
verification/rvc_checker.sv
verification/tb_rvc_expander.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rvc expander testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rvc_expander \
    -f rvc_expander.f \
    --Mdir obj_dir -o sim_rvc_expander
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/sim_rvc_expander)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: verification/tb_rvc_expander.sv
////////////////////
// rvc expander testbench
// random and directed words with a credit-returning consumer
////////////////////

`timescale 1ns/1ps

module tb_rvc_expander;

    import rvc_pkg::*;

    localparam int unsigned CREDITS        = 4;
    localparam int unsigned WORDS_PER_TEST = 500;
    localparam int unsigned TIMEOUT_CYCLES = 4 * WORDS_PER_TEST * 8;
    localparam logic [31:0] SEED           = 32'h90042cac;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_t      in_instr;
    logic        in_ready;
    logic        credit;
    logic        out_valid;
    dec_result_t out_result;
    int unsigned errors;
    int unsigned pending;

    int unsigned occupied;
    int unsigned credit_pct;
    int unsigned stalls;
    int unsigned cycles = 0;
    int unsigned passed;
    int unsigned failed;

    rvc_expander #(
        .CREDITS (CREDITS)
    ) u_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .valid_i  (in_valid),
        .instr_i  (in_instr),
        .credit_i (credit),
        .ready_o  (in_ready),
        .valid_o  (out_valid),
        .result_o (out_result)
    );

    rvc_checker #(
        .CREDITS (CREDITS)
    ) u_checker (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .in_valid_i    (in_valid),
        .in_instr_i    (in_instr),
        .in_ready_i    (in_ready),
        .credit_i      (credit),
        .out_valid_i   (out_valid),
        .out_result_i  (out_result),
        .error_count_o (errors),
        .pending_o     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, words stopped flowing through the DUT", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // one falling edge, then the consumer frees a slot at random
    task automatic next_cycle();
        @(negedge clk);
        if (out_valid) begin
            occupied++;
        end
        credit = 1'b0;
        if (occupied > 0 && $urandom_range(99, 0) < credit_pct) begin
            credit = 1'b1;
            occupied--;
        end
    endtask

    task automatic send_word(input instr_t w);
        in_valid = 1'b1;
        in_instr = w;
        while (!in_ready) begin
            stalls++;
            next_cycle();
        end
        next_cycle();
    endtask

    function automatic cinstr_t corner_word(input int unsigned idx);
        case (idx)
            0:       return 16'h0010;  // c.addi4spn, zero immediate
            1:       return 16'h4002;  // c.lwsp x0
            2:       return 16'h8002;  // c.jr x0
            3:       return 16'h9002;  // c.ebreak
            4:       return 16'h6081;  // c.lui, zero immediate
            default: return 16'h9005;  // c.srli with bit 12 set
        endcase
    endfunction

    function automatic instr_t make_word(input int unsigned kind, input int unsigned idx);
        instr_t w;
        w = $urandom;
        case (kind)
            1:       w[1:0] = 2'b11;
            2:       w[1:0] = 2'($urandom_range(2, 0));
            3:       w[15:0] = corner_word(idx);
            default: w = w;
        endcase
        return w;
    endfunction

    task automatic run_test(input int unsigned kind, input string name,
                            input int unsigned pct, input int unsigned idle_pct);
        int unsigned errors_before;
        int unsigned count;
        int unsigned i;
        logic        ok;
        errors_before = errors;
        credit_pct    = pct;
        stalls        = 0;
        count         = (kind == 3) ? 6 : WORDS_PER_TEST;
        for (i = 0; i < count; i++) begin
            send_word(make_word(kind, i));
            if ($urandom_range(99, 0) < idle_pct) begin
                in_valid = 1'b0;
                in_instr = $urandom;
                next_cycle();
            end
        end
        in_valid = 1'b0;
        // the consumer empties its slots so the next test starts with every credit
        while (pending != 0 || occupied != 0) begin
            next_cycle();
        end
        next_cycle();
        ok = (errors == errors_before);
        if (kind == 5 && stalls != 0) begin
            $display("full throughput stalled for %0d cycles with credits returned at once",
                     stalls);
            ok = 1'b0;
        end
        $display("test %0d %s: %s, %0d errors", kind, name, ok ? "ok" : "FAILED",
                 errors - errors_before);
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        credit     = 1'b0;
        occupied   = 0;
        credit_pct = 0;
        passed     = 0;
        failed     = 0;
        repeat (2) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        run_test(1, "pass-through", 50, 25);
        run_test(2, "quadrant expansion", 50, 25);
        run_test(3, "legality corners", 50, 0);
        run_test(4, "credit back-pressure", 15, 0);
        run_test(5, "full throughput", 100, 0);

        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/rvc_checker.sv
////////////////////
// rvc expander checker
// reference expansion model, expected result queue
// and credit bookkeeping for the downstream side
////////////////////

`timescale 1ns/1ps

module rvc_checker #(
    parameter int unsigned CREDITS = rvc_pkg::CREDITS_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  rvc_pkg::instr_t      in_instr_i,
    input  logic                 in_ready_i,
    input  logic                 credit_i,
    input  logic                 out_valid_i,
    input  rvc_pkg::dec_result_t out_result_i,
    output int unsigned          error_count_o,
    output int unsigned          pending_o
);

    import rvc_pkg::*;

    dec_result_t expect_q[$];
    dec_result_t exp_res;
    int          credits;
    int unsigned delivered;
    int unsigned returned;
    int unsigned errors = 0;
    logic        accepted;
    logic        accepted_q;

    assign error_count_o = errors;

    ////////////////////
    // encoding helpers
    ////////////////////

    function automatic reg_addr_t xreg(creg_t f);
        return reg_addr_t'(5'd8 + {2'b00, f});
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_r(logic f7b5, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_b(logic [12:0] imm, reg_addr_t rs1, logic bne);
        return {imm[12], imm[10:5], REG_ZERO, rs1, 2'b00, bne, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // expected expansion, instr is only meaningful when legal
    function automatic dec_result_t expand(instr_t w);
        cinstr_t            c;
        logic signed [31:0] imm;
        reg_addr_t          rd;
        reg_addr_t          rs2;
        reg_addr_t          r_hi;
        reg_addr_t          r_lo;
        logic [2:0]         f3;
        dec_result_t        r;
        c         = w[15:0];
        rd        = c[11:7];
        rs2       = c[6:2];
        r_hi      = xreg(c[9:7]);
        r_lo      = xreg(c[4:2]);
        r.instr   = w;
        r.illegal = 1'b0;
        case ({c[1:0], c[15:13]})
            5'b00_000: begin
                imm       = {c[10:7], c[12:11], c[5], c[6], 2'b00};
                r.instr   = enc_i(imm[11:0], REG_SP, 3'b000, r_lo, OPC_OP_IMM);
                r.illegal = (imm == 0);
            end
            5'b00_010: begin
                imm     = {c[5], c[12:10], c[6], 2'b00};
                r.instr = enc_i(imm[11:0], r_hi, 3'b010, r_lo, OPC_LOAD);
            end
            5'b00_110: begin
                imm     = {c[5], c[12:10], c[6], 2'b00};
                r.instr = enc_s(imm[11:0], r_lo, r_hi);
            end
            5'b01_000, 5'b01_010: begin
                // c.li reads x0, c.addi reads rd
                imm     = $signed({c[12], c[6:2]});
                r.instr = enc_i(imm[11:0], c[14] ? REG_ZERO : rd, 3'b000, rd, OPC_OP_IMM);
            end
            5'b01_001, 5'b01_101: begin
                imm     = $signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0});
                r.instr = enc_j(imm[20:0], c[15] ? REG_ZERO : REG_RA);
            end
            5'b01_011: begin
                if (rd == REG_SP) begin
                    imm     = $signed({c[12], c[4:3], c[5], c[2], c[6], 4'b0000});
                    r.instr = enc_i(imm[11:0], REG_SP, 3'b000, REG_SP, OPC_OP_IMM);
                end else begin
                    imm     = $signed({c[12], c[6:2], 12'h000});
                    r.instr = {imm[31:12], rd, OPC_LUI};
                end
                r.illegal = (imm == 0);
            end
            5'b01_100: begin
                case (c[6:5])
                    2'b00:   f3 = 3'b000;
                    2'b01:   f3 = 3'b100;
                    2'b10:   f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                imm = $signed({c[12], c[6:2]});
                if (c[11:10] == 2'b10) begin
                    r.instr = enc_i(imm[11:0], r_hi, 3'b111, r_hi, OPC_OP_IMM);
                end else if (c[11:10] == 2'b11) begin
                    r.instr   = enc_r(c[6:5] == 2'b00, r_lo, r_hi, f3, r_hi);
                    r.illegal = c[12];
                end else begin
                    r.instr   = enc_i({1'b0, c[10], 5'b00000, c[6:2]}, r_hi, 3'b101, r_hi,
                                      OPC_OP_IMM);
                    r.illegal = c[12];
                end
            end
            5'b01_110, 5'b01_111: begin
                imm     = $signed({c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0});
                r.instr = enc_b(imm[12:0], r_hi, c[13]);
            end
            5'b10_000: begin
                r.instr   = enc_i({7'b0000000, rs2}, rd, 3'b001, rd, OPC_OP_IMM);
                r.illegal = c[12];
            end
            5'b10_010: begin
                imm       = {c[3:2], c[12], c[6:4], 2'b00};
                r.instr   = enc_i(imm[11:0], REG_SP, 3'b010, rd, OPC_LOAD);
                r.illegal = (rd == REG_ZERO);
            end
            5'b10_100: begin
                if (rs2 != REG_ZERO) begin
                    // c.mv adds to x0, c.add to rd
                    r.instr = enc_r(1'b0, rs2, c[12] ? rd : REG_ZERO, 3'b000, rd);
                end else if (c[12] && rd == REG_ZERO) begin
                    r.instr = enc_i(12'h001, REG_ZERO, 3'b000, REG_ZERO, OPC_SYSTEM);
                end else begin
                    r.instr   = enc_i(12'h000, rd, 3'b000, c[12] ? REG_RA : REG_ZERO, OPC_JALR);
                    r.illegal = !c[12] && (rd == REG_ZERO);
                end
            end
            5'b10_110: begin
                imm     = {c[8:7], c[12:9], 2'b00};
                r.instr = enc_s(imm[11:0], rs2, REG_SP);
            end
            default: begin
                // full-width words pass, every other slot is reserved
                r.illegal = (c[1:0] != 2'b11);
            end
        endcase
        return r;
    endfunction

    ////////////////////
    // comparison
    ////////////////////

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            expect_q.delete();
            credits    = CREDITS;
            delivered  = 0;
            returned   = 0;
            accepted_q = 1'b0;
        end else begin
            if (in_ready_i !== (credits != 0)) begin
                $display("ERROR ready_o expected %h got %h", credits != 0, in_ready_i);
                errors++;
            end
            if (out_valid_i !== accepted_q) begin
                $display("ERROR valid_o expected %h got %h", accepted_q, out_valid_i);
                errors++;
            end
            if (out_valid_i === 1'b1) begin
                delivered++;
                if (delivered > CREDITS + returned) begin
                    $display("more results were delivered than credits were granted");
                    errors++;
                end
                if (expect_q.size() == 0) begin
                    $display("a result came out with no accepted word waiting for it");
                    errors++;
                end else begin
                    exp_res = expect_q.pop_front();
                    if (out_result_i.illegal !== exp_res.illegal) begin
                        $display("ERROR result_o.illegal expected %h got %h (word %h)",
                                 exp_res.illegal, out_result_i.illegal, exp_res.instr);
                        errors++;
                    end else if (!exp_res.illegal && out_result_i.instr !== exp_res.instr) begin
                        $display("ERROR result_o.instr expected %h got %h",
                                 exp_res.instr, out_result_i.instr);
                        errors++;
                    end
                end
            end
            accepted = in_valid_i && in_ready_i;
            if (accepted) begin
                expect_q.push_back(expand(in_instr_i));
                credits--;
            end
            if (credit_i) begin
                credits++;
                returned++;
            end
            accepted_q = accepted;
        end
        pending_o = expect_q.size();
    end

endmodule

// File: hdl/rvc_expander.sv
////////////////////
// rvc expander top level
// picks a quadrant decoder and registers the result
// under credit flow control toward the consumer
////////////////////

`timescale 1ns/1ps

module rvc_expander #(
    parameter int unsigned CREDITS = rvc_pkg::CREDITS_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  rvc_pkg::instr_t      instr_i,
    input  logic                 credit_i,
    output logic                 ready_o,
    output logic                 valid_o,
    output rvc_pkg::dec_result_t result_o
);

    import rvc_pkg::*;

    localparam int unsigned CNT_W = $clog2(CREDITS + 1);

    typedef logic [CNT_W-1:0] credit_cnt_t;

    cinstr_t     cinstr;
    dec_result_t res_q0;
    dec_result_t res_q1;
    dec_result_t res_q2;
    dec_result_t res_sel;
    credit_cnt_t credit_cnt_q;
    logic        accept;

    ////////////////////
    // decode
    ////////////////////

    assign cinstr = instr_i[15:0];

    rvc_quadrant0 u_q0 (
        .cinstr_i (cinstr),
        .result_o (res_q0)
    );

    rvc_quadrant1 u_q1 (
        .cinstr_i (cinstr),
        .result_o (res_q1)
    );

    rvc_quadrant2 u_q2 (
        .cinstr_i (cinstr),
        .result_o (res_q2)
    );

    always_comb begin
        case (instr_i[1:0])
            2'b00:   res_sel = res_q0;
            2'b01:   res_sel = res_q1;
            2'b10:   res_sel = res_q2;
            // full-width word goes through untouched
            default: res_sel = '{instr: instr_i, illegal: 1'b0};
        endcase
    end

    ////////////////////
    // output register and credits
    ////////////////////

    // ready comes only from the credit count
    assign ready_o = (credit_cnt_q != '0);
    assign accept  = valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            credit_cnt_q <= credit_cnt_t'(CREDITS);
        end else begin
            valid_o <= accept;
            // a take and a return in one cycle cancel out
            case ({accept, credit_i})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            result_o <= res_sel;
        end
    end

    ////////////////////
    // assertions
    ////////////////////

    a_quadrant_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !$isunknown(instr_i[1:0]));

    // funct3 steers every quadrant decoder
    a_selector_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && instr_i[1:0] != 2'b11) |-> !$isunknown(instr_i[15:13]));

    // no result may follow a cycle spent without credits
    a_no_issue_at_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && credit_cnt_q == '0) |=> !valid_o);

    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt_q <= credit_cnt_t'(CREDITS));

endmodule

// File: hdl/rvc_quadrant2.sv
////////////////////
// rvc quadrant 2 decoder
// expands sp-relative and register-move forms
////////////////////

`timescale 1ns/1ps

module rvc_quadrant2 (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::dec_result_t result_o
);

    import rvc_pkg::*;

    reg_addr_t rd;
    reg_addr_t rs2;

    assign rd  = cinstr_i[11:7];
    assign rs2 = cinstr_i[6:2];

    always_comb begin
        result_o.instr   = {16'h0000, cinstr_i};
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.slli
                result_o.instr   = {7'b0000000, rs2, rd, 3'b001, rd, OPC_OP_IMM};
                result_o.illegal = cinstr_i[12];
            end
            3'b010: begin
                // c.lwsp, rd of x0 is reserved
                result_o.instr = {4'b0000, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                                  REG_SP, 3'b010, rd, OPC_LOAD};
                if (rd == REG_ZERO) begin
                    result_o.illegal = 1'b1;
                end
            end
            3'b100: begin
                ////////////////////
                // funct4 group
                ////////////////////
                if (!cinstr_i[12]) begin
                    if (rs2 != REG_ZERO) begin
                        // c.mv
                        result_o.instr = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OPC_OP};
                    end else begin
                        // c.jr
                        result_o.instr = {12'h000, rd, 3'b000, REG_ZERO, OPC_JALR};
                        if (rd == REG_ZERO) begin
                            result_o.illegal = 1'b1;
                        end
                    end
                end else if (rs2 != REG_ZERO) begin
                    // c.add
                    result_o.instr = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
                end else if (rd == REG_ZERO) begin
                    result_o.instr = INSTR_EBREAK;
                end else begin
                    // c.jalr
                    result_o.instr = {12'h000, rd, 3'b000, REG_RA, OPC_JALR};
                end
            end
            3'b110: begin
                // c.swsp
                result_o.instr = {4'b0000, cinstr_i[8:7], cinstr_i[12], rs2, REG_SP, 3'b010,
                                  cinstr_i[11:9], 2'b00, OPC_STORE};
            end
            default: begin
                result_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/rvc_quadrant1.sv
////////////////////
// rvc quadrant 1 decoder
// expands immediates, jumps, branches and alu ops
////////////////////

`timescale 1ns/1ps

module rvc_quadrant1 (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::dec_result_t result_o
);

    import rvc_pkg::*;

    reg_addr_t rd;
    reg_addr_t rd_p;
    reg_addr_t rs2_p;
    reg_addr_t jal_rd;
    logic [2:0] alu_f3;

    assign rd     = cinstr_i[11:7];
    assign rd_p   = creg_to_reg(cinstr_i[9:7]);
    assign rs2_p  = creg_to_reg(cinstr_i[4:2]);
    // c.jal links through ra, c.j discards the link
    assign jal_rd = cinstr_i[15] ? REG_ZERO : REG_RA;

    // funct3 of the register-register group
    always_comb begin
        case (cinstr_i[6:5])
            2'b00:   alu_f3 = 3'b000;
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
    end

    always_comb begin
        result_o.instr   = {16'h0000, cinstr_i};
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.addi, c.nop when rd is x0
                result_o.instr = {{7{cinstr_i[12]}}, cinstr_i[6:2], rd, 3'b000, rd, OPC_OP_IMM};
            end
            3'b001, 3'b101: begin
                result_o.instr = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                                  cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                                  {9{cinstr_i[12]}}, jal_rd, OPC_JAL};
            end
            3'b010: begin
                // c.li
                result_o.instr = {{7{cinstr_i[12]}}, cinstr_i[6:2], REG_ZERO, 3'b000, rd,
                                  OPC_OP_IMM};
            end
            3'b011: begin
                if (rd == REG_SP) begin
                    // c.addi16sp, immediate in units of 16
                    result_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                                      cinstr_i[6], 4'b0000, REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
                end else begin
                    // c.lui
                    result_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, OPC_LUI};
                end
                if ({cinstr_i[12], cinstr_i[6:2]} == 6'b000000) begin
                    result_o.illegal = 1'b1;
                end
            end
            3'b100: begin
                case (cinstr_i[11:10])
                    2'b00, 2'b01: begin
                        // c.srli / c.srai, bit 10 selects arithmetic
                        result_o.instr = {1'b0, cinstr_i[10], 5'b00000, cinstr_i[6:2], rd_p,
                                          3'b101, rd_p, OPC_OP_IMM};
                        // shamt[5] only exists on rv64
                        result_o.illegal = cinstr_i[12];
                    end
                    2'b10: begin
                        // c.andi
                        result_o.instr = {{7{cinstr_i[12]}}, cinstr_i[6:2], rd_p, 3'b111, rd_p,
                                          OPC_OP_IMM};
                    end
                    default: begin
                        // c.sub, c.xor, c.or, c.and, bit 12 set is the rv64 word group
                        result_o.instr = {1'b0, (cinstr_i[6:5] == 2'b00), 5'b00000, rs2_p, rd_p,
                                          alu_f3, rd_p, OPC_OP};
                        result_o.illegal = cinstr_i[12];
                    end
                endcase
            end
            default: begin
                // c.beqz / c.bnez, bit 13 picks bne
                result_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], REG_ZERO, rd_p,
                                  2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                                  cinstr_i[12], OPC_BRANCH};
            end
        endcase
    end

endmodule

// File: hdl/rvc_quadrant0.sv
////////////////////
// rvc quadrant 0 decoder
// expands c.addi4spn, c.lw and c.sw
////////////////////

`timescale 1ns/1ps

module rvc_quadrant0 (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::dec_result_t result_o
);

    import rvc_pkg::*;

    reg_addr_t rd_p;
    reg_addr_t rs1_p;

    // rd' and rs2' share bits 4:2 in this quadrant
    assign rd_p  = creg_to_reg(cinstr_i[4:2]);
    assign rs1_p = creg_to_reg(cinstr_i[9:7]);

    always_comb begin
        result_o.instr   = {16'h0000, cinstr_i};
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.addi4spn, zero-extended immediate scaled by 4
                result_o.instr = {2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5],
                                  cinstr_i[6], 2'b00, REG_SP, 3'b000, rd_p, OPC_OP_IMM};
                // all-zero immediate is reserved
                if (cinstr_i[12:5] == 8'h00) begin
                    result_o.illegal = 1'b1;
                end
            end
            3'b010: begin
                // c.lw
                result_o.instr = {5'b00000, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                                  rs1_p, 3'b010, rd_p, OPC_LOAD};
            end
            3'b110: begin
                // c.sw, immediate split around rs2' and rs1'
                result_o.instr = {5'b00000, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, 3'b010,
                                  cinstr_i[11:10], cinstr_i[6], 2'b00, OPC_STORE};
            end
            default: begin
                // fp loads and stores and reserved encodings
                result_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/rvc_pkg.sv
////////////////////
// rvc shared definitions
// instruction types, opcodes and the decode result
////////////////////

package rvc_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [15:0] cinstr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  creg_t;
    typedef logic [6:0]  opcode_t;

    // one expanded instruction plus its legality flag
    typedef struct packed {
        instr_t instr;
        logic   illegal;
    } dec_result_t;

    // major opcodes of the rv32i base set
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd1;
    localparam reg_addr_t REG_SP   = 5'd2;

    localparam instr_t INSTR_EBREAK = {12'h001, 13'h0000, OPC_SYSTEM};

    localparam int unsigned CREDITS_DEFAULT = 4;

    // compressed register fields only reach x8 to x15
    function automatic reg_addr_t creg_to_reg(creg_t creg);
        return {2'b01, creg};
    endfunction

endpackage
